// File: verilog.f
+incdir+rtl
rtl/rvcpu_pkg.sv
rtl/if_stage.sv
rtl/inst_buffer.sv
rtl/regfile.sv
rtl/id_stage.sv
rtl/ex_stage.sv
rtl/rvcpu.sv
verification/rvcpu_sva.sv
verification/rvcpu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the rvcpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rvcpu_tb -f verilog.f -o rvcpu_sim

status=0
output=$(./obj_dir/rvcpu_sim) || status=$?
echo "$output"
[ "$status" -eq 0 ]
echo "$output" | grep -q '^>>> PASS$'

// File: verification/rvcpu_tb.sv
`timescale 1ns/1ps

`include "rvcpu_defs.svh"

module rvcpu_tb import rvcpu_pkg::*; ();

typedef enum int {
	K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_ADDI, K_LUI, K_BEQ, K_BNE, K_JAL
} kind_e;

logic               clk;
logic               arst_n_i;
logic               if_ready_i;
logic [1:0]         if_resp_i;
logic [`INST_W-1:0] if_data_read_i;
logic               if_valid_o;
logic [`XLEN-1:0]   if_addr_o;
logic               commit_valid_o;
commit_pkt_t        commit_o;

int seed = 32'h5273;

// program and the fields it was built from
logic [31:0] prog [256];
kind_e       kind_m [256];
logic [4:0]  rd_m [256];
logic [4:0]  rs1_m [256];
logic [4:0]  rs2_m [256];
logic [63:0] imm_m [256];

// expected commit stream from the ISA model
logic [63:0] exp_pc [256];
logic [31:0] exp_inst [256];
logic        exp_wen [256];
logic [4:0]  exp_rd [256];
logic [63:0] exp_data [256];
int          nexp;
int          taken_cnt;

commit_pkt_t first_run [256];
commit_pkt_t second_run [256];
int          errors;
int          test_errors;
int          tests;
longint      limit_ns;

rvcpu dut_i (
	.clk            (clk),
	.arst_n_i       (arst_n_i),
	.if_ready_i     (if_ready_i),
	.if_resp_i      (if_resp_i),
	.if_data_read_i (if_data_read_i),
	.if_valid_o     (if_valid_o),
	.if_addr_o      (if_addr_o),
	.commit_valid_o (commit_valid_o),
	.commit_o       (commit_o)
);

initial begin
	clk = 1'b0;
	forever #10 clk = ~clk;
end

function automatic logic [31:0] rand_word();
	return $random(seed);
endfunction

function automatic int rand_below(input int n);
	logic [31:0] r;
	r = $random(seed);
	return int'(r % n);
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [4:0] rd);
	return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
	return {imm, rd, 7'b0110111};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
	if (got !== exp) begin
		$display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
		errors++;
		test_errors++;
	end
endtask

task automatic report_test(input string name);
	tests++;
	$display("test %-32s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "failed",
		test_errors);
	test_errors = 0;
endtask

// small register set so that dependencies and x0 writes are frequent
task automatic build_program();
	logic [31:0] r;
	logic [4:0]  rs1;
	logic [63:0] off;
	int          span;
	for (int i = 0; i < 255; i++) begin
		r         = rand_word();
		kind_m[i] = kind_e'(rand_below(11));
		rd_m[i]   = 5'(rand_below(8));
		rs1       = 5'(rand_below(8));
		rs1_m[i]  = rs1;
		rs2_m[i]  = (rand_below(2) == 0) ? rs1 : 5'(rand_below(8));
		span      = (255 - i < 4) ? 255 - i : 4;
		off       = 64'(1 + rand_below(span)) * 64'd4;
		imm_m[i]  = off;
		case (kind_m[i])
			K_ADD: prog[i] = enc_r(7'h00, rs2_m[i], rs1, 3'b000, rd_m[i]);
			K_SUB: prog[i] = enc_r(7'h20, rs2_m[i], rs1, 3'b000, rd_m[i]);
			K_AND: prog[i] = enc_r(7'h00, rs2_m[i], rs1, 3'b111, rd_m[i]);
			K_OR:  prog[i] = enc_r(7'h00, rs2_m[i], rs1, 3'b110, rd_m[i]);
			K_XOR: prog[i] = enc_r(7'h00, rs2_m[i], rs1, 3'b100, rd_m[i]);
			K_SLT: prog[i] = enc_r(7'h00, rs2_m[i], rs1, 3'b010, rd_m[i]);
			K_ADDI: begin
				imm_m[i] = {{52{r[11]}}, r[11:0]};
				prog[i]  = enc_i(r[11:0], rs1, rd_m[i]);
			end
			K_LUI: begin
				imm_m[i] = {{32{r[31]}}, r[31:12], 12'b0};
				prog[i]  = enc_u(r[31:12], rd_m[i]);
			end
			K_BEQ: prog[i] = enc_b(off[12:0], rs2_m[i], rs1, 3'b000);
			K_BNE: prog[i] = enc_b(off[12:0], rs2_m[i], rs1, 3'b001);
			default: prog[i] = enc_j(off[20:0], rd_m[i]);
		endcase
	end
	// jal x0,0 parks the core at the end
	kind_m[255] = K_JAL;
	rd_m[255]   = 5'd0;
	rs1_m[255]  = 5'd0;
	rs2_m[255]  = 5'd0;
	imm_m[255]  = 64'd0;
	prog[255]   = enc_j(21'd0, 5'd0);
endtask

// in-order ISA model, runs until the parking jump retires once
task automatic run_model();
	logic [63:0] x [32];
	logic [63:0] a;
	logic [63:0] b;
	logic [63:0] data;
	logic [63:0] pc;
	logic        wen;
	int          idx;
	int          next;
	for (int i = 0; i < 32; i++)
		x[i] = 64'd0;
	idx       = 0;
	nexp      = 0;
	taken_cnt = 0;
	while (nexp < 256) begin
		a    = x[rs1_m[idx]];
		b    = x[rs2_m[idx]];
		pc   = 64'(idx) * 64'd4;
		wen  = 1'b1;
		data = 64'd0;
		next = idx + 1;
		case (kind_m[idx])
			K_ADD:  data = a + b;
			K_SUB:  data = a - b;
			K_AND:  data = a & b;
			K_OR:   data = a | b;
			K_XOR:  data = a ^ b;
			K_SLT:  data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			K_ADDI: data = a + imm_m[idx];
			K_LUI:  data = imm_m[idx];
			K_BEQ, K_BNE: begin
				wen = 1'b0;
				if ((a == b) == (kind_m[idx] == K_BEQ)) begin
					next = idx + int'(imm_m[idx] >> 2);
					taken_cnt++;
				end
			end
			default: begin
				data = pc + 64'd4;
				next = idx + int'(imm_m[idx] >> 2);
				taken_cnt++;
			end
		endcase
		wen = wen && (rd_m[idx] != 5'd0);
		if (wen)
			x[rd_m[idx]] = data;
		exp_pc[nexp]   = pc;
		exp_inst[nexp] = prog[idx];
		exp_wen[nexp]  = wen;
		exp_rd[nexp]   = rd_m[idx];
		exp_data[nexp] = data;
		nexp++;
		if (idx == 255)
			break;
		idx = next;
	end
endtask

task automatic drive_fetch(input bit random_ready);
	logic [31:0] r;
	r              = rand_word();
	if_ready_i     = random_ready ? r[0] : 1'b1;
	if_data_read_i = (if_addr_o < 64'd1024) ? prog[if_addr_o[9:2]] : 32'h00000013;
endtask

task automatic run_program(input bit random_ready, input string tag);
	int n;
	bit fetched;
	n       = 0;
	fetched = 1'b0;
	@(posedge clk);
	#1;
	arst_n_i   = 1'b0;
	if_ready_i = 1'b0;
	repeat (8) @(posedge clk);
	#1;
	arst_n_i = 1'b1;
	drive_fetch(random_ready);
	@(negedge clk);
	check_value("if_valid_o", 64'(if_valid_o), 64'd1);
	check_value("if_addr_o", if_addr_o, `RESET_PC);
	report_test({"reset state, ", tag});
	while (1) begin
		if (commit_valid_o && n < nexp) begin
			if (!fetched) begin
				$display("commit seen before the first fetch completed at t=%0t", $time);
				errors++;
				test_errors++;
			end
			check_value("commit_o.pc", commit_o.pc, exp_pc[n]);
			check_value("commit_o.inst", 64'(commit_o.inst), 64'(exp_inst[n]));
			check_value("commit_o.rd_wen", 64'(commit_o.rd_wen), 64'(exp_wen[n]));
			if (exp_wen[n]) begin
				check_value("commit_o.rd", 64'(commit_o.rd), 64'(exp_rd[n]));
				check_value("commit_o.rd_data", commit_o.rd_data, exp_data[n]);
			end
			if (random_ready)
				second_run[n] = commit_o;
			else
				first_run[n] = commit_o;
			n++;
		end
		if (if_valid_o && if_ready_i)
			fetched = 1'b1;
		if (n == nexp)
			break;
		@(posedge clk);
		#1;
		drive_fetch(random_ready);
		@(negedge clk);
	end
	report_test({"commit stream, ", tag});
endtask

initial begin : watchdog
	wait (limit_ns != 0);
	#(limit_ns);
	$display("timeout: the core stopped committing before the expected stream ended");
	$display(">>> FAIL");
	$finish;
end

initial begin
	arst_n_i       = 1'b0;
	if_ready_i     = 1'b0;
	if_resp_i      = 2'b00;
	if_data_read_i = '0;
	errors         = 0;
	test_errors    = 0;
	tests          = 0;
	limit_ns       = 0;
	build_program();
	run_model();
	limit_ns = longint'(2 * (nexp * 20 + 20)) * 20;
	run_program(1'b0, "ready high");
	run_program(1'b1, "random ready");
	for (int i = 0; i < nexp; i++) begin
		check_value("run2 commit_o.pc", second_run[i].pc, first_run[i].pc);
		check_value("run2 commit_o.rd_wen", 64'(second_run[i].rd_wen),
			64'(first_run[i].rd_wen));
		check_value("run2 commit_o.rd_data", second_run[i].rd_data, first_run[i].rd_data);
	end
	report_test("back-pressure stream match");
	$display("summary: %0d tests, %0d commits per run, %0d taken redirects, %0d errors",
		tests, nexp, taken_cnt, errors);
	if (errors == 0)
		$display(">>> PASS");
	else
		$display(">>> FAIL");
	$finish;
end

endmodule

// File: verification/rvcpu_sva.sv
`timescale 1ns/1ps

`include "rvcpu_defs.svh"

module rvcpu_sva import rvcpu_pkg::*; (
	input logic             clk,
	input logic             arst_n_i,
	input logic             if_valid_o,
	input logic             if_ready_i,
	input logic [`XLEN-1:0] if_addr_o,
	input logic             commit_valid_o,
	input commit_pkt_t      commit_o
);

// a waiting request keeps its address
addr_stable_a: assert property (@(posedge clk) disable iff (!arst_n_i)
	(if_valid_o && !if_ready_i) |=> (if_valid_o && $stable(if_addr_o)))
	else $error("fetch address changed while the request was waiting");

commit_in_reset_a: assert property (@(posedge clk)
	!arst_n_i |-> !commit_valid_o)
	else $error("commit_valid_o high during reset");

// x0 is never a write target on the commit port
no_x0_write_a: assert property (@(posedge clk) disable iff (!arst_n_i)
	(commit_valid_o && commit_o.rd_wen) |-> (commit_o.rd != '0))
	else $error("committed register write targets x0");

endmodule

bind rvcpu rvcpu_sva rvcpu_sva_i (
	.clk            (clk),
	.arst_n_i       (arst_n_i),
	.if_valid_o     (if_valid_o),
	.if_ready_i     (if_ready_i),
	.if_addr_o      (if_addr_o),
	.commit_valid_o (commit_valid_o),
	.commit_o       (commit_o)
);

// File: rtl/rvcpu.sv
`timescale 1ns/1ps

`include "rvcpu_defs.svh"

module rvcpu import rvcpu_pkg::*; (
	input  logic               clk,
	input  logic               arst_n_i,

	// fetch bus
	input  logic               if_ready_i,
	input  logic [1:0]         if_resp_i,
	input  logic [`INST_W-1:0] if_data_read_i,
	output logic               if_valid_o,
	output logic [`XLEN-1:0]   if_addr_o,

	// retired instruction stream
	output logic               commit_valid_o,
	output commit_pkt_t        commit_o
);

// if_resp_i is part of the bus but error responses are not modeled

logic               buf_room;
logic               push;
fetch_pkt_t         push_pkt;
logic               head_valid;
fetch_pkt_t         head;
logic               pop;
logic               issue_valid;
issue_pkt_t         issue;
logic [`REG_AW-1:0] raddr1;
logic [`REG_AW-1:0] raddr2;
logic [`XLEN-1:0]   rdata1;
logic [`XLEN-1:0]   rdata2;
wb_pkt_t            wb;
redirect_t          redirect;

if_stage if_stage_i (
	.clk            (clk),
	.arst_n_i       (arst_n_i),
	.if_ready_i     (if_ready_i),
	.if_data_read_i (if_data_read_i),
	.buf_room_i     (buf_room),
	.redirect_i     (redirect),
	.if_valid_o     (if_valid_o),
	.if_addr_o      (if_addr_o),
	.push_o         (push),
	.push_pkt_o     (push_pkt)
);

// the open bus request counts as a claimed slot
inst_buffer inst_buffer_i (
	.clk          (clk),
	.arst_n_i     (arst_n_i),
	.push_i       (push),
	.push_pkt_i   (push_pkt),
	.pop_i        (pop),
	.flush_i      (redirect.taken),
	.pending_i    (if_valid_o),
	.head_valid_o (head_valid),
	.head_o       (head),
	.room_o       (buf_room)
);

id_stage id_stage_i (
	.head_valid_i  (head_valid),
	.head_i        (head),
	.redirect_i    (redirect),
	.rdata1_i      (rdata1),
	.rdata2_i      (rdata2),
	.bypass_i      (wb),
	.raddr1_o      (raddr1),
	.raddr2_o      (raddr2),
	.pop_o         (pop),
	.issue_valid_o (issue_valid),
	.issue_o       (issue)
);

regfile regfile_i (
	.clk      (clk),
	.arst_n_i (arst_n_i),
	.wena_i   (wb.wen),
	.waddr_i  (wb.rd),
	.wdata_i  (wb.data),
	.raddr1_i (raddr1),
	.raddr2_i (raddr2),
	.rdata1_o (rdata1),
	.rdata2_o (rdata2)
);

ex_stage ex_stage_i (
	.clk            (clk),
	.arst_n_i       (arst_n_i),
	.issue_valid_i  (issue_valid),
	.issue_i        (issue),
	.wb_o           (wb),
	.redirect_o     (redirect),
	.commit_valid_o (commit_valid_o),
	.commit_o       (commit_o)
);

endmodule

// File: rtl/ex_stage.sv
`timescale 1ns/1ps

`include "rvcpu_defs.svh"

module ex_stage import rvcpu_pkg::*; (
	input  logic        clk,
	input  logic        arst_n_i,
	input  logic        issue_valid_i,
	input  issue_pkt_t  issue_i,
	output wb_pkt_t     wb_o,
	output redirect_t   redirect_o,
	output logic        commit_valid_o,
	output commit_pkt_t commit_o
);

logic             valid_q;
issue_pkt_t       ex_q;
logic [`XLEN-1:0] opa;
logic [`XLEN-1:0] opb;
logic [`XLEN-1:0] link_pc;
logic [`XLEN-1:0] result;
logic             taken;

// issue register
always_ff @(posedge clk or negedge arst_n_i) begin
	if (!arst_n_i)
		valid_q <= 1'b0;
	else
		valid_q <= issue_valid_i;
end

always_ff @(posedge clk) begin
	if (issue_valid_i)
		ex_q <= issue_i;
end

assign opa     = ex_q.rs1_val;
assign opb     = ex_q.use_imm ? ex_q.imm : ex_q.rs2_val;
assign link_pc = ex_q.pc + `XLEN'd4;

always_comb begin
	result = '0;
	taken  = 1'b0;
	case (ex_q.op)
		OP_ADD: result = opa + opb;
		OP_SUB: result = opa - opb;
		OP_AND: result = opa & opb;
		OP_OR:  result = opa | opb;
		OP_XOR: result = opa ^ opb;
		OP_SLT: result = `XLEN'($signed(opa) < $signed(opb));
		OP_LUI: result = ex_q.imm;
		OP_BEQ: taken = opa == opb;
		OP_BNE: taken = opa != opb;
		OP_JAL: begin
			result = link_pc;
			taken  = 1'b1;
		end
		default: ;
	endcase
end

// written at the edge that makes the commit visible
assign wb_o.wen  = valid_q & ex_q.rd_wen;
assign wb_o.rd   = ex_q.rd;
assign wb_o.data = result;

// branch and jal targets are both pc relative
assign redirect_o.taken  = valid_q & taken;
assign redirect_o.target = ex_q.pc + ex_q.imm;

always_ff @(posedge clk or negedge arst_n_i) begin
	if (!arst_n_i)
		commit_valid_o <= 1'b0;
	else
		commit_valid_o <= valid_q;
end

always_ff @(posedge clk) begin
	if (valid_q) begin
		commit_o.pc      <= ex_q.pc;
		commit_o.inst    <= ex_q.inst;
		commit_o.rd_wen  <= wb_o.wen;
		commit_o.rd      <= wb_o.rd;
		commit_o.rd_data <= wb_o.data;
	end
end

endmodule

// File: rtl/id_stage.sv
`timescale 1ns/1ps

`include "rvcpu_defs.svh"

module id_stage import rvcpu_pkg::*; (
	input  logic               head_valid_i,
	input  fetch_pkt_t         head_i,
	input  redirect_t          redirect_i,
	input  logic [`XLEN-1:0]   rdata1_i,
	input  logic [`XLEN-1:0]   rdata2_i,
	input  wb_pkt_t            bypass_i,
	output logic [`REG_AW-1:0] raddr1_o,
	output logic [`REG_AW-1:0] raddr2_o,
	output logic               pop_o,
	output logic               issue_valid_o,
	output issue_pkt_t         issue_o
);

logic [`INST_W-1:0] inst;
logic [2:0]         funct3;
logic [6:0]         funct7;
logic [`REG_AW-1:0] rs1;
logic [`REG_AW-1:0] rs2;
logic [`REG_AW-1:0] rd;
logic [`XLEN-1:0]   imm_i;
logic [`XLEN-1:0]   imm_u;
logic [`XLEN-1:0]   imm_b;
logic [`XLEN-1:0]   imm_j;
logic [`XLEN-1:0]   imm;
alu_op_e            op;
logic               use_imm;
logic               rd_write;

// the result still in execute wins over the stale register value
function automatic logic [`XLEN-1:0] operand(input logic [`REG_AW-1:0] src,
		input logic [`XLEN-1:0] rf_val, input wb_pkt_t byp);
	if (byp.wen && byp.rd == src && src != '0)
		return byp.data;
	return rf_val;
endfunction

assign inst   = head_i.inst;
assign funct3 = inst[14:12];
assign funct7 = inst[31:25];
assign rs1    = inst[19:15];
assign rs2    = inst[24:20];
assign rd     = inst[11:7];

assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

always_comb begin
	op       = OP_NOP;
	use_imm  = 1'b0;
	rd_write = 1'b0;
	imm      = imm_i;
	case (opcode_e'(inst[6:0]))
		OPC_OP: begin
			if (funct7 == 7'b0000000) begin
				rd_write = 1'b1;
				case (funct3)
					3'b000: op = OP_ADD;
					3'b010: op = OP_SLT;
					3'b100: op = OP_XOR;
					3'b110: op = OP_OR;
					3'b111: op = OP_AND;
					default: rd_write = 1'b0;
				endcase
			end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
				op       = OP_SUB;
				rd_write = 1'b1;
			end
		end
		OPC_OP_IMM: begin
			// only addi
			if (funct3 == 3'b000) begin
				op       = OP_ADD;
				use_imm  = 1'b1;
				rd_write = 1'b1;
			end
		end
		OPC_LUI: begin
			op       = OP_LUI;
			imm      = imm_u;
			use_imm  = 1'b1;
			rd_write = 1'b1;
		end
		OPC_BRANCH: begin
			imm = imm_b;
			if (funct3 == 3'b000)
				op = OP_BEQ;
			else if (funct3 == 3'b001)
				op = OP_BNE;
		end
		OPC_JAL: begin
			op       = OP_JAL;
			imm      = imm_j;
			rd_write = 1'b1;
		end
		default: ;
	endcase
end

assign raddr1_o = rs1;
assign raddr2_o = rs2;

// nothing leaves decode while execute is redirecting
assign issue_valid_o = head_valid_i & ~redirect_i.taken;
assign pop_o         = issue_valid_o;

assign issue_o.pc      = head_i.pc;
assign issue_o.inst    = inst;
assign issue_o.op      = op;
assign issue_o.use_imm = use_imm;
assign issue_o.imm     = imm;
assign issue_o.rs1_val = operand(rs1, rdata1_i, bypass_i);
assign issue_o.rs2_val = operand(rs2, rdata2_i, bypass_i);
assign issue_o.rd      = rd;
assign issue_o.rd_wen  = rd_write & (rd != '0);

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps

`include "rvcpu_defs.svh"

module regfile (
	input  logic               clk,
	input  logic               arst_n_i,
	input  logic               wena_i,
	input  logic [`REG_AW-1:0] waddr_i,
	input  logic [`XLEN-1:0]   wdata_i,
	input  logic [`REG_AW-1:0] raddr1_i,
	input  logic [`REG_AW-1:0] raddr2_i,
	output logic [`XLEN-1:0]   rdata1_o,
	output logic [`XLEN-1:0]   rdata2_o
);

logic [`XLEN-1:0] regs_q [`REG_NUM];

// x0 is cleared here and never written after
always_ff @(posedge clk or negedge arst_n_i) begin
	if (!arst_n_i) begin
		for (int i = 0; i < `REG_NUM; i++)
			regs_q[i] <= '0;
	end else if (wena_i && waddr_i != '0) begin
		regs_q[waddr_i] <= wdata_i;
	end
end

assign rdata1_o = regs_q[raddr1_i];
assign rdata2_o = regs_q[raddr2_i];

endmodule

// File: rtl/inst_buffer.sv
`timescale 1ns/1ps

`include "rvcpu_defs.svh"

module inst_buffer import rvcpu_pkg::*; (
	input  logic       clk,
	input  logic       arst_n_i,
	input  logic       push_i,
	input  fetch_pkt_t push_pkt_i,
	input  logic       pop_i,
	input  logic       flush_i,
	input  logic       pending_i,
	output logic       head_valid_o,
	output fetch_pkt_t head_o,
	output logic       room_o
);

localparam int PTR_W = (`IBUF_DEPTH > 1) ? $clog2(`IBUF_DEPTH) : 1;
localparam int CNT_W = $clog2(`IBUF_DEPTH + 1);

fetch_pkt_t       mem_q [`IBUF_DEPTH];
logic [PTR_W-1:0] rd_ptr_q;
logic [PTR_W-1:0] wr_ptr_q;
logic [CNT_W-1:0] count_q;
logic [CNT_W:0]   demand;

function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
	if (ptr == PTR_W'(`IBUF_DEPTH - 1))
		return '0;
	return ptr + PTR_W'(1);
endfunction

always_ff @(posedge clk or negedge arst_n_i) begin
	if (!arst_n_i) begin
		rd_ptr_q <= '0;
		wr_ptr_q <= '0;
		count_q  <= '0;
	end else if (flush_i) begin
		rd_ptr_q <= '0;
		wr_ptr_q <= '0;
		count_q  <= '0;
	end else begin
		if (push_i)
			wr_ptr_q <= ptr_inc(wr_ptr_q);
		if (pop_i)
			rd_ptr_q <= ptr_inc(rd_ptr_q);
		case ({push_i, pop_i})
			2'b10: count_q <= count_q + CNT_W'(1);
			2'b01: count_q <= count_q - CNT_W'(1);
			default: ;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (push_i)
		mem_q[wr_ptr_q] <= push_pkt_i;
end

// slots claimed after this edge, the fetch on the bus included
assign demand = {1'b0, count_q} + (CNT_W+1)'(pending_i) - (CNT_W+1)'(pop_i);
assign room_o = demand < (CNT_W+1)'(`IBUF_DEPTH);

assign head_valid_o = count_q != '0;
assign head_o       = mem_q[rd_ptr_q];

endmodule

// File: rtl/if_stage.sv
`timescale 1ns/1ps

`include "rvcpu_defs.svh"

module if_stage import rvcpu_pkg::*; (
	input  logic               clk,
	input  logic               arst_n_i,
	input  logic               if_ready_i,
	input  logic [`INST_W-1:0] if_data_read_i,
	input  logic               buf_room_i,
	input  redirect_t          redirect_i,
	output logic               if_valid_o,
	output logic [`XLEN-1:0]   if_addr_o,
	output logic               push_o,
	output fetch_pkt_t         push_pkt_o
);

logic             req_q;
logic             stale_q;
logic [`XLEN-1:0] pc_q;
logic [`XLEN-1:0] tgt_q;
logic             accept;
logic             waiting;

assign accept  = req_q & if_ready_i;
assign waiting = req_q & ~if_ready_i;

always_ff @(posedge clk or negedge arst_n_i) begin
	if (!arst_n_i) begin
		req_q   <= 1'b1;
		stale_q <= 1'b0;
		pc_q    <= `RESET_PC;
	end else begin
		// a request on the bus holds until it is taken
		if (!waiting)
			req_q <= buf_room_i;

		if (redirect_i.taken) begin
			// keep the bus address stable, drop the word when it arrives
			if (waiting) begin
				stale_q <= 1'b1;
			end else begin
				pc_q    <= redirect_i.target;
				stale_q <= 1'b0;
			end
		end else if (accept) begin
			pc_q    <= stale_q ? tgt_q : pc_q + `XLEN'd4;
			stale_q <= 1'b0;
		end
	end
end

// where to go once the stale fetch is done
always_ff @(posedge clk) begin
	if (redirect_i.taken)
		tgt_q <= redirect_i.target;
end

assign if_valid_o = req_q;
assign if_addr_o  = pc_q;

assign push_o          = accept & ~stale_q & ~redirect_i.taken;
assign push_pkt_o.pc   = pc_q;
assign push_pkt_o.inst = if_data_read_i;

endmodule

// File: rtl/rvcpu_pkg.sv
`include "rvcpu_defs.svh"

package rvcpu_pkg;

	// operation carried from decode to execute
	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_LUI,
		OP_BEQ,
		OP_BNE,
		OP_JAL,
		OP_NOP
	} alu_op_e;

	// major opcodes the decoder knows about
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef struct packed {
		logic [`XLEN-1:0]   pc;
		logic [`INST_W-1:0] inst;
	} fetch_pkt_t;

	typedef struct packed {
		logic [`XLEN-1:0]   pc;
		logic [`INST_W-1:0] inst;
		alu_op_e            op;
		logic               use_imm;
		logic [`XLEN-1:0]   imm;
		logic [`XLEN-1:0]   rs1_val;
		logic [`XLEN-1:0]   rs2_val;
		logic [`REG_AW-1:0] rd;
		logic               rd_wen;
	} issue_pkt_t;

	typedef struct packed {
		logic               wen;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0]   data;
	} wb_pkt_t;

	// difftest style record of one retired instruction
	typedef struct packed {
		logic [`XLEN-1:0]   pc;
		logic [`INST_W-1:0] inst;
		logic               rd_wen;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0]   rd_data;
	} commit_pkt_t;

	typedef struct packed {
		logic             taken;
		logic [`XLEN-1:0] target;
	} redirect_t;

endpackage

// File: rtl/rvcpu_defs.svh
`ifndef RVCPU_DEFS_SVH
`define RVCPU_DEFS_SVH

// data path and pc width
`define XLEN 64

// fetched instruction width
`define INST_W 32

// register file geometry
`define REG_AW 5
`define REG_NUM 32

// address of the first fetch after reset
`define RESET_PC 64'h0

// slots in the queue between fetch and decode
`define IBUF_DEPTH 2

`endif
